/* hw/dcore_defs.svh */
`ifndef DCORE_DEFS_SVH
`define DCORE_DEFS_SVH

// number of time-interleaved slices
`define DC_SLICES 4

// magnitude width of one slice
`define DC_ADC_W 8

// prbs order and checker history depth
`define DC_PRBS_N 7

// error and total counters
`define DC_CNT_W 32

// apb byte address width
`define DC_APB_AW 8

// register byte offsets
`define DC_REG_CTRL 8'h00
`define DC_REG_THRESH 8'h04
`define DC_REG_EQN 8'h08
`define DC_REG_INJ 8'h0C
// slice offsets follow at 4-byte steps up to 0x1C
`define DC_REG_OFS0 8'h10
`define DC_REG_ERR 8'h20
`define DC_REG_TOT 8'h24

`endif

/* hw/dcore_pkg.sv */
`include "dcore_defs.svh"

package dcore_pkg;

    // raw magnitude of one adc slice
    typedef logic [`DC_ADC_W-1:0] adc_mag_t;

    // unfolded sample with the sign bit on top of the magnitude
    typedef logic signed [`DC_ADC_W:0] sample_t;

    // one bit per slice for decisions and lane enables
    typedef logic [`DC_SLICES-1:0] lane_mask_t;

    // bit k selects the history bit at delay k+1
    typedef logic [`DC_PRBS_N-1:0] prbs_eqn_t;

    // error and total counters
    typedef logic [`DC_CNT_W-1:0] count_t;

endpackage

/* hw/dcore_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcore_defs.svh"

interface dcore_cfg_if import dcore_pkg::*; ();

    // unfolding and slicing
    sample_t    offsets [`DC_SLICES];
    sample_t    thresh;

    // bist generator
    logic       gen_en;
    prbs_eqn_t  eqn;
    logic       inj_err;

    // checker control
    logic       chk_run;
    logic       chk_src;
    lane_mask_t lane_en;

    // checker status back to the register block
    count_t     err_count;
    count_t     total_count;

    modport regs (
        output offsets, thresh, gen_en, eqn, inj_err, chk_run, chk_src, lane_en,
        input  err_count, total_count
    );

    modport frontend (
        input offsets, thresh
    );

    modport gen (
        input gen_en, eqn, inj_err
    );

    // eqn is shared with the generator so both ends use the same polynomial
    modport chk (
        input  eqn, chk_run, chk_src, lane_en,
        output err_count, total_count
    );

endinterface

`default_nettype wire

/* hw/apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcore_defs.svh"

module apb_regs import dcore_pkg::*; (
    input  wire logic                  clk_adc,
    input  wire logic                  rst_n_i,
    input  wire logic                  psel_i,
    input  wire logic                  penable_i,
    input  wire logic                  pwrite_i,
    input  wire logic [`DC_APB_AW-1:0] paddr_i,
    input  wire logic [31:0]           pwdata_i,
    output logic      [31:0]           prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    dcore_cfg_if.regs                  cfg
);

    // x^7 + x^6 + 1 with taps at delays 7 and 6
    localparam prbs_eqn_t EQN_RST = 7'b110_0000;

    logic       access;
    logic       wr_en;
    logic       reg_hit;
    lane_mask_t ofs_hit;

    assign access = psel_i & penable_i;

    // one hit per slice offset register
    always_comb begin
        for (int k = 0; k < `DC_SLICES; k++) begin
            ofs_hit[k] = (32'(paddr_i) == `DC_REG_OFS0 + 4 * k);
        end
    end

    always_comb begin
        case (paddr_i)
            `DC_REG_CTRL, `DC_REG_THRESH, `DC_REG_EQN, `DC_REG_INJ,
            `DC_REG_ERR, `DC_REG_TOT: reg_hit = 1'b1;
            default: reg_hit = |ofs_hit;
        endcase
    end

    // zero wait states and errors only on unmapped addresses
    assign pready_o  = 1'b1;
    assign pslverr_o = access & ~reg_hit;
    assign wr_en     = access & pwrite_i;

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            cfg.gen_en  <= 1'b0;
            cfg.chk_run <= 1'b0;
            cfg.chk_src <= 1'b0;
            cfg.lane_en <= '0;
            cfg.thresh  <= '0;
            cfg.eqn     <= EQN_RST;
            cfg.inj_err <= 1'b0;
            for (int k = 0; k < `DC_SLICES; k++) begin
                cfg.offsets[k] <= '0;
            end
        end else begin
            // inj_err lasts a single cycle
            cfg.inj_err <= 1'b0;
            if (wr_en) begin
                case (paddr_i)
                    `DC_REG_CTRL: begin
                        cfg.gen_en  <= pwdata_i[0];
                        cfg.chk_run <= pwdata_i[1];
                        cfg.chk_src <= pwdata_i[2];
                        cfg.lane_en <= pwdata_i[4 +: `DC_SLICES];
                    end
                    `DC_REG_THRESH: cfg.thresh <= sample_t'(pwdata_i[`DC_ADC_W:0]);
                    `DC_REG_EQN: cfg.eqn <= pwdata_i[`DC_PRBS_N-1:0];
                    `DC_REG_INJ: cfg.inj_err <= pwdata_i[0];
                    // counters are read only
                    default: ;
                endcase
                for (int k = 0; k < `DC_SLICES; k++) begin
                    if (ofs_hit[k]) begin
                        cfg.offsets[k] <= sample_t'(pwdata_i[`DC_ADC_W:0]);
                    end
                end
            end
        end
    end

    // signed fields come back sign extended
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            `DC_REG_CTRL: begin
                prdata_o[0]                = cfg.gen_en;
                prdata_o[1]                = cfg.chk_run;
                prdata_o[2]                = cfg.chk_src;
                prdata_o[4 +: `DC_SLICES] = cfg.lane_en;
            end
            `DC_REG_THRESH: prdata_o = 32'(cfg.thresh);
            `DC_REG_EQN: prdata_o = 32'(cfg.eqn);
            `DC_REG_ERR: prdata_o = 32'(cfg.err_count);
            `DC_REG_TOT: prdata_o = 32'(cfg.total_count);
            default: begin
                for (int k = 0; k < `DC_SLICES; k++) begin
                    if (ofs_hit[k]) begin
                        prdata_o = 32'(cfg.offsets[k]);
                    end
                end
            end
        endcase
    end

    // an errored write leaves the configuration untouched
    a_slverr_no_write: assert property (
        @(posedge clk_adc) disable iff (!rst_n_i)
        (pslverr_o && pwrite_i) |=> $stable({cfg.gen_en, cfg.chk_run, cfg.chk_src,
                                             cfg.lane_en, cfg.thresh, cfg.eqn})
    );

endmodule

`default_nettype wire

/* hw/adc_frontend.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcore_defs.svh"

module adc_frontend import dcore_pkg::*; (
    input  wire logic                              clk_adc,
    input  wire logic                              rst_n_i,
    input  wire logic [`DC_SLICES*`DC_ADC_W-1:0]  adc_mag_i,
    input  wire lane_mask_t                        adc_sign_i,
    dcore_cfg_if.frontend                          cfg,
    output lane_mask_t                             adc_bits_o
);

    // room for sample minus offset without overflow
    typedef logic signed [`DC_ADC_W+1:0] corr_t;

    sample_t unfolded [`DC_SLICES];
    corr_t   corr_q   [`DC_SLICES];

    // sign bit 1 means positive
    always_comb begin
        adc_mag_t mag;
        for (int k = 0; k < `DC_SLICES; k++) begin
            mag = adc_mag_i[k*`DC_ADC_W +: `DC_ADC_W];
            if (adc_sign_i[k]) begin
                unfolded[k] = sample_t'({1'b0, mag});
            end else begin
                unfolded[k] = -sample_t'({1'b0, mag});
            end
        end
    end

    // first stage holds the offset corrected sample
    always_ff @(posedge clk_adc) begin
        for (int k = 0; k < `DC_SLICES; k++) begin
            corr_q[k] <= unfolded[k] - cfg.offsets[k];
        end
    end

    // second stage compares strictly against the threshold
    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            adc_bits_o <= '0;
        end else begin
            for (int k = 0; k < `DC_SLICES; k++) begin
                adc_bits_o[k] <= (corr_q[k] > cfg.thresh);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/prbs_gen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcore_defs.svh"

module prbs_gen import dcore_pkg::*; (
    input  wire logic  clk_adc,
    input  wire logic  rst_n_i,
    dcore_cfg_if.gen   cfg,
    output logic       bist_bit_o
);

    // lfsr_q[k] holds the bit generated k+1 cycles ago
    prbs_eqn_t lfsr_q;
    logic      feedback;

    assign feedback = ^(lfsr_q & cfg.eqn);

    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            lfsr_q <= '1;
        end else if (cfg.gen_en) begin
            lfsr_q <= {lfsr_q[`DC_PRBS_N-2:0], feedback};
        end
    end

    // newest bit is flipped for one cycle on injection
    assign bist_bit_o = lfsr_q[0] ^ cfg.inj_err;

    // an all-zero state would lock the generator
    a_lfsr_alive: assert property (
        @(posedge clk_adc) disable iff (!rst_n_i)
        cfg.gen_en |=> (lfsr_q != '0)
    );

endmodule

`default_nettype wire

/* hw/prbs_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcore_defs.svh"

module prbs_checker import dcore_pkg::*; (
    input  wire logic        clk_adc,
    input  wire logic        rst_n_i,
    input  wire lane_mask_t  adc_bits_i,
    input  wire logic        bist_bit_i,
    dcore_cfg_if.chk         cfg
);

    // wide enough to count every lane in one cycle
    localparam int CW = $clog2(`DC_SLICES + 1);

    lane_mask_t          rx_bits;
    lane_mask_t          err_bits;
    prbs_eqn_t           hist_q [`DC_SLICES];
    logic [CW-1:0]       n_en;
    logic [CW-1:0]       n_err;
    logic [`DC_CNT_W:0]  err_sum;
    logic [`DC_CNT_W:0]  tot_sum;

    always_comb begin
        rx_bits = cfg.chk_src ? {`DC_SLICES{bist_bit_i}} : adc_bits_i;
        n_en    = '0;
        n_err   = '0;
        for (int k = 0; k < `DC_SLICES; k++) begin
            // predicted bit is the xor of the tapped history
            err_bits[k] = rx_bits[k] ^ (^(hist_q[k] & cfg.eqn));
            n_en        = n_en + CW'(cfg.lane_en[k]);
            n_err       = n_err + CW'(err_bits[k] & cfg.lane_en[k]);
        end
        err_sum = {1'b0, cfg.err_count} + {{(`DC_CNT_W + 1 - CW){1'b0}}, n_err};
        tot_sum = {1'b0, cfg.total_count} + {{(`DC_CNT_W + 1 - CW){1'b0}}, n_en};
    end

    // history runs regardless of chk_run so the check starts in sync
    always_ff @(posedge clk_adc) begin
        if (!rst_n_i) begin
            for (int k = 0; k < `DC_SLICES; k++) begin
                hist_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `DC_SLICES; k++) begin
                hist_q[k] <= {hist_q[k][`DC_PRBS_N-2:0], rx_bits[k]};
            end
        end
    end

    // counters clear while stopped and saturate on carry out
    always_ff @(posedge clk_adc) begin
        if (!rst_n_i || !cfg.chk_run) begin
            cfg.err_count   <= '0;
            cfg.total_count <= '0;
        end else begin
            cfg.err_count   <= err_sum[`DC_CNT_W] ? '1 : err_sum[`DC_CNT_W-1:0];
            cfg.total_count <= tot_sum[`DC_CNT_W] ? '1 : tot_sum[`DC_CNT_W-1:0];
        end
    end

    a_err_le_total: assert property (
        @(posedge clk_adc) disable iff (!rst_n_i)
        cfg.err_count <= cfg.total_count
    );

endmodule

`default_nettype wire

/* hw/dcore_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcore_defs.svh"

module dcore_top import dcore_pkg::*; (
    input  wire logic                              clk_adc,
    input  wire logic                              rst_n_i,

    // apb slave
    input  wire logic                              psel_i,
    input  wire logic                              penable_i,
    input  wire logic                              pwrite_i,
    input  wire logic [`DC_APB_AW-1:0]             paddr_i,
    input  wire logic [31:0]                       pwdata_i,
    output wire logic [31:0]                       prdata_o,
    output wire logic                              pready_o,
    output wire logic                              pslverr_o,

    // adc slices with slice 0 in the lsbs
    input  wire logic [`DC_SLICES*`DC_ADC_W-1:0]  adc_mag_i,
    input  wire logic [`DC_SLICES-1:0]             adc_sign_i
);

    dcore_cfg_if cfg_if ();

    lane_mask_t adc_bits;
    logic       bist_bit;

    apb_regs u_regs (
        .clk_adc   (clk_adc),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .cfg       (cfg_if.regs)
    );

    adc_frontend u_frontend (
        .clk_adc    (clk_adc),
        .rst_n_i    (rst_n_i),
        .adc_mag_i  (adc_mag_i),
        .adc_sign_i (adc_sign_i),
        .cfg        (cfg_if.frontend),
        .adc_bits_o (adc_bits)
    );

    // bist source for the checker
    prbs_gen u_gen (
        .clk_adc    (clk_adc),
        .rst_n_i    (rst_n_i),
        .cfg        (cfg_if.gen),
        .bist_bit_o (bist_bit)
    );

    prbs_checker u_checker (
        .clk_adc    (clk_adc),
        .rst_n_i    (rst_n_i),
        .adc_bits_i (adc_bits),
        .bist_bit_i (bist_bit),
        .cfg        (cfg_if.chk)
    );

endmodule

`default_nettype wire

/* tests/tb_apb_tasks.svh */
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// cycles to wait for pready before giving up on an access
localparam int APB_TIMEOUT = 16;

// drives a setup then an access phase and returns on the falling edge after it
task automatic apb_access(input logic is_write, input logic [`DC_APB_AW-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic slverr);
    int waited;
    waited = 0;
    @(negedge clk_adc);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = is_write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_adc);
    penable_i = 1'b1;
    @(posedge clk_adc);
    while (pready_o !== 1'b1 && waited < APB_TIMEOUT) begin
        @(posedge clk_adc);
        waited++;
    end
    if (pready_o !== 1'b1) begin
        timeouts++;
        $display("timeout: no pready for the APB access to address 0x%02h", addr);
    end
    rdata  = prdata_o;
    slverr = pslverr_o;
    @(negedge clk_adc);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
endtask

// a write to a mapped register must not error
task automatic write_reg(input logic [`DC_APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] discard;
    logic        err;
    apb_access(1'b1, addr, data, discard, err);
    check_true("apb_write", !err, "pslverr was raised on a write to a mapped register");
endtask

// a read of a mapped register must not error
task automatic read_reg(input logic [`DC_APB_AW-1:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_true("apb_read", !err, "pslverr was raised on a read of a mapped register");
endtask

`endif

/* tests/tb_dcore.sv */
`timescale 1ns/1ps
`include "dcore_defs.svh"

module tb_dcore;

    localparam int POLL_LIMIT  = 200;
    localparam int WARM_CYCLES = 12;

    logic                             clk_adc;
    logic                             rst_n_i;
    logic                             psel_i;
    logic                             penable_i;
    logic                             pwrite_i;
    logic [`DC_APB_AW-1:0]            paddr_i;
    logic [31:0]                      pwdata_i;
    logic [31:0]                      prdata_o;
    logic                             pready_o;
    logic                             pslverr_o;
    logic [`DC_SLICES*`DC_ADC_W-1:0]  adc_mag_i;
    logic [`DC_SLICES-1:0]            adc_sign_i;

    integer               seed;
    int                   errors;
    int                   timeouts;
    int                   checks;
    logic [`DC_ADC_W-1:0] mag_floor;
    logic [31:0]          rdata;
    logic [31:0]          err_cnt;
    logic [31:0]          tot_cnt;
    logic                 slverr;

    dcore_top u_dcore_top (.*);

    initial begin
        clk_adc = 1'b0;
        forever #10 clk_adc = ~clk_adc;
    end

    // new magnitudes every falling edge and never below mag_floor
    always @(negedge clk_adc) begin
        logic [31:0] rnd;
        for (int k = 0; k < `DC_SLICES; k++) begin
            rnd = $random(seed);
            adc_mag_i[k*`DC_ADC_W +: `DC_ADC_W] = mag_floor + {1'b0, rnd[6:0]};
        end
    end

    a_pready_high: assert property (@(posedge clk_adc) disable iff (!rst_n_i) pready_o)
        else begin
            errors++;
            $display("pready_o went low although the slave has no wait states");
        end

    task automatic compare_word(input string test, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("MISMATCH %s expected 0x%08h actual 0x%08h", test, expected, actual);
        end
    endtask

    task automatic check_true(input string test, input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s: %s", test, what);
        end
    endtask

    // CTRL holds gen_en, chk_run and chk_src, then lane_en from bit 4
    function automatic logic [31:0] ctrl_word(input logic gen, input logic run,
                                              input logic src,
                                              input logic [`DC_SLICES-1:0] lanes);
        return {{(28 - `DC_SLICES){1'b0}}, lanes, 1'b0, src, run, gen};
    endfunction

    `include "tb_apb_tasks.svh"

    task automatic wait_total_growth(input int growth);
        logic [31:0] first;
        logic [31:0] last;
        int          polls;
        polls = 0;
        read_reg(`DC_REG_TOT, first);
        last = first;
        while (last - first < growth && polls < POLL_LIMIT) begin
            read_reg(`DC_REG_TOT, last);
            polls++;
        end
        if (last - first < growth) begin
            timeouts++;
            $display("timeout: total_count grew by %0d, expected at least %0d",
                     last - first, growth);
        end
    endtask

    // history fills while chk_run is low
    // zero lanes with chk_run high holds the counts
    task automatic run_and_freeze(input logic gen, input logic src,
                                  input logic [`DC_SLICES-1:0] lanes, input int growth);
        write_reg(`DC_REG_CTRL, ctrl_word(gen, 1'b0, src, lanes));
        repeat (WARM_CYCLES) @(negedge clk_adc);
        write_reg(`DC_REG_CTRL, ctrl_word(gen, 1'b1, src, lanes));
        wait_total_growth(growth);
        write_reg(`DC_REG_CTRL, ctrl_word(gen, 1'b1, src, '0));
        read_reg(`DC_REG_ERR, err_cnt);
        read_reg(`DC_REG_TOT, tot_cnt);
    endtask

    initial begin
        seed       = 32'h2c5d_6d08;
        errors     = 0;
        timeouts   = 0;
        checks     = 0;
        mag_floor  = '0;
        rst_n_i    = 1'b0;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        pwrite_i   = 1'b0;
        paddr_i    = '0;
        pwdata_i   = '0;
        adc_mag_i  = '0;
        adc_sign_i = '0;
        repeat (3) @(posedge clk_adc);
        @(negedge clk_adc);
        rst_n_i = 1'b1;

        // register access and reset values
        read_reg(`DC_REG_CTRL, rdata);
        compare_word("reset_ctrl", 32'h0, rdata);
        read_reg(`DC_REG_THRESH, rdata);
        compare_word("reset_thresh", 32'h0, rdata);
        read_reg(`DC_REG_EQN, rdata);
        compare_word("reset_eqn", 32'h60, rdata);
        write_reg(`DC_REG_THRESH, 32'h25);
        read_reg(`DC_REG_THRESH, rdata);
        compare_word("thresh_readback", 32'h25, rdata);
        write_reg(`DC_REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b1, 4'b1010));
        read_reg(`DC_REG_CTRL, rdata);
        compare_word("ctrl_readback", ctrl_word(1'b0, 1'b0, 1'b1, 4'b1010), rdata);
        apb_access(1'b0, 8'h30, '0, rdata, slverr);
        compare_word("unmapped_slverr", 32'h1, 32'(slverr));
        apb_access(1'b1, `DC_REG_ERR, 32'hdead, rdata, slverr);
        compare_word("err_write_slverr", 32'h0, 32'(slverr));
        read_reg(`DC_REG_ERR, rdata);
        compare_word("err_read_only", 32'h0, rdata);
        write_reg(`DC_REG_THRESH, 32'h0);

        // clean bist stream on all lanes
        run_and_freeze(1'b1, 1'b1, 4'hf, 200);
        compare_word("bist_clean_err", 32'h0, err_cnt);
        compare_word("bist_clean_total_mod4", 32'h0, tot_cnt % 4);
        check_true("bist_clean_total", tot_cnt != 0, "total_count stayed at zero");

        // single injected error on lanes 0 and 1
        write_reg(`DC_REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b1, 4'b0011));
        repeat (WARM_CYCLES) @(negedge clk_adc);
        write_reg(`DC_REG_CTRL, ctrl_word(1'b1, 1'b1, 1'b1, 4'b0011));
        wait_total_growth(40);
        read_reg(`DC_REG_ERR, err_cnt);
        compare_word("inject_err_before", 32'h0, err_cnt);
        write_reg(`DC_REG_INJ, 32'h1);
        wait_total_growth(40);
        read_reg(`DC_REG_ERR, rdata);
        // bad bit is seen as data and again at delay 6 and delay 7
        compare_word("inject_err_delta", err_cnt + 3 * 2, rdata);

        // negative samples against threshold 0 give a zero stream
        adc_sign_i = '0;
        run_and_freeze(1'b0, 1'b0, 4'hf, 100);
        compare_word("adc_zero_err", 32'h0, err_cnt);
        check_true("adc_zero_total", tot_cnt != 0, "total_count stayed at zero");

        // x^7+x^6+1 predicts 0 for all ones so every bit is an error
        mag_floor  = 8'd40;
        adc_sign_i = '1;
        write_reg(`DC_REG_THRESH, 32'd10);
        for (int k = 0; k < `DC_SLICES; k++) begin
            write_reg(`DC_REG_OFS0 + 8'(4 * k), 32'd20);
        end
        run_and_freeze(1'b0, 1'b0, 4'hf, 100);
        compare_word("adc_ones_err", tot_cnt, err_cnt);
        check_true("adc_ones_total", tot_cnt != 0, "total_count stayed at zero");

        // slice 2 offset above any magnitude forces its decisions to 0
        write_reg(`DC_REG_OFS0 + 8'h08, 32'd200);
        run_and_freeze(1'b0, 1'b0, 4'b0100, 50);
        compare_word("ofs2_err", 32'h0, err_cnt);
        check_true("ofs2_total", tot_cnt != 0, "total_count stayed at zero");

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+hw
+incdir+tests
hw/dcore_pkg.sv
hw/dcore_cfg_if.sv
hw/apb_regs.sv
hw/adc_frontend.sv
hw/prbs_gen.sv
hw/prbs_checker.sv
hw/dcore_top.sv
tests/tb_dcore.sv

/* Bender.yml */
package:
  name: dcore

sources:
  - include_dirs:
      - hw
    files:
      - hw/dcore_pkg.sv
      - hw/dcore_cfg_if.sv
      - hw/apb_regs.sv
      - hw/adc_frontend.sv
      - hw/prbs_gen.sv
      - hw/prbs_checker.sv
      - hw/dcore_top.sv
  - target: test
    include_dirs:
      - hw
      - tests
    files:
      - tests/tb_dcore.sv
